// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal --Mdir obj_dir
TOP       ?= raster_tb
FILELIST  ?= src.f
PASS_TEXT := TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^$(PASS_TEXT)$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== design/raster_params.svh ====
`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// Screen coordinate width, 6 bits gives a 64 by 64 screen
`define RASTER_SCREEN_BITS 6

// Vertex and color words carry three fields
`define RASTER_WORD_BITS 96

// One field of a word: x, y, z or red, green, blue
`define RASTER_FIELD_BITS 32

// Default depth of the vertex and color FIFOs
`define RASTER_FIFO_DEPTH 16

`endif

// ==== design/raster_pkg.sv ====
`include "raster_params.svh"

package raster_pkg;

  // Full vertex or color word
  // x (or red) in the top field, y (or green) in the middle, z (or blue) at the bottom
  typedef logic [`RASTER_WORD_BITS-1:0] word_t;

  // Single field of a word
  typedef logic [`RASTER_FIELD_BITS-1:0] field_t;

  // Unsigned screen coordinate, low bits of an x or y field
  typedef logic [`RASTER_SCREEN_BITS-1:0] coord_t;

  // Signed edge function value
  // Two signed differences multiplied, then one product minus another
  typedef logic signed [2*`RASTER_SCREEN_BITS+3:0] edge_t;

  // Assembler FSM
  typedef enum logic {
    ASM_COLLECT,
    ASM_HOLD
  } asm_state_t;

  // Rasterizer FSM
  typedef enum logic [1:0] {
    RAS_IDLE,
    RAS_SETUP,
    RAS_SCAN
  } ras_state_t;

endpackage

// ==== design/raster_top.sv ====
`include "raster_params.svh"

module raster_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               vertex_wr_en,
  input  raster_pkg::word_t  vertex_wr_data,
  output logic               vertex_full,
  input  logic               color_wr_en,
  input  raster_pkg::word_t  color_wr_data,
  output logic               color_full,
  input  logic               pix_full,
  output logic               pix_wr_en,
  output raster_pkg::coord_t pix_x,
  output raster_pkg::coord_t pix_y,
  output raster_pkg::word_t  pix_color
);

  import raster_pkg::*;

  word_t  vertex_rd_data;
  word_t  color_rd_data;
  logic   vertex_empty;
  logic   color_empty;
  logic   rd_en;
  logic   tri_valid;
  logic   tri_ready;
  coord_t x0;
  coord_t y0;
  coord_t x1;
  coord_t y1;
  coord_t x2;
  coord_t y2;
  word_t  tri_color;

  //////////////////////////////
  // Input FIFOs
  //////////////////////////////

  sync_fifo #(
    .DEPTH(`RASTER_FIFO_DEPTH)
  ) vertex_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (vertex_wr_en),
    .wr_data (vertex_wr_data),
    .rd_en   (rd_en),
    .rd_data (vertex_rd_data),
    .full    (vertex_full),
    .empty   (vertex_empty)
  );

  sync_fifo #(
    .DEPTH(`RASTER_FIFO_DEPTH)
  ) color_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (color_wr_en),
    .wr_data (color_wr_data),
    .rd_en   (rd_en),
    .rd_data (color_rd_data),
    .full    (color_full),
    .empty   (color_empty)
  );

  //////////////////////////////
  // Assembly and scan
  //////////////////////////////

  triangle_assembler assembler_inst (
    .clk            (clk),
    .rst            (rst),
    .vertex_empty   (vertex_empty),
    .color_empty    (color_empty),
    .vertex_rd_data (vertex_rd_data),
    .color_rd_data  (color_rd_data),
    .rd_en          (rd_en),
    .tri_ready      (tri_ready),
    .tri_valid      (tri_valid),
    .x0             (x0),
    .y0             (y0),
    .x1             (x1),
    .y1             (y1),
    .x2             (x2),
    .y2             (y2),
    .tri_color      (tri_color)
  );

  triangle_rasterizer rasterizer_inst (
    .clk       (clk),
    .rst       (rst),
    .tri_valid (tri_valid),
    .tri_ready (tri_ready),
    .x0        (x0),
    .y0        (y0),
    .x1        (x1),
    .y1        (y1),
    .x2        (x2),
    .y2        (y2),
    .tri_color (tri_color),
    .pix_full  (pix_full),
    .pix_wr_en (pix_wr_en),
    .pix_x     (pix_x),
    .pix_y     (pix_y),
    .pix_color (pix_color)
  );

endmodule

// ==== design/sync_fifo.sv ====
`include "raster_params.svh"

module sync_fifo #(
  parameter int DEPTH = `RASTER_FIFO_DEPTH
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wr_en,
  input  raster_pkg::word_t wr_data,
  input  logic              rd_en,
  output raster_pkg::word_t rd_data,
  output logic              full,
  output logic              empty
);

  import raster_pkg::*;

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  word_t               mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                do_wr;
  logic                do_rd;

  // Accepted operations only
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign full  = (count == CNT_BITS'(DEPTH));
  assign empty = (count == '0);

  // Storage
  always_ff @(posedge clk)
  begin
    if (do_wr)
    begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Registered read port, data shows up one cycle after rd_en
  always_ff @(posedge clk)
  begin
    if (do_rd)
    begin
      rd_data <= mem[rd_ptr];
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
      begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd)
      begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== design/triangle_assembler.sv ====
`include "raster_params.svh"

module triangle_assembler (
  input  logic               clk,
  input  logic               rst,
  input  logic               vertex_empty,
  input  logic               color_empty,
  input  raster_pkg::word_t  vertex_rd_data,
  input  raster_pkg::word_t  color_rd_data,
  output logic               rd_en,
  input  logic               tri_ready,
  output logic               tri_valid,
  output raster_pkg::coord_t x0,
  output raster_pkg::coord_t y0,
  output raster_pkg::coord_t x1,
  output raster_pkg::coord_t y1,
  output raster_pkg::coord_t x2,
  output raster_pkg::coord_t y2,
  output raster_pkg::word_t  tri_color
);

  import raster_pkg::*;

  asm_state_t state;
  logic [1:0] slot;
  logic       pending;
  field_t     field_x;
  field_t     field_y;
  coord_t     cur_x;
  coord_t     cur_y;

  // Vertex fields, z is not used
  assign field_x = vertex_rd_data[2*`RASTER_FIELD_BITS +: `RASTER_FIELD_BITS];
  assign field_y = vertex_rd_data[`RASTER_FIELD_BITS +: `RASTER_FIELD_BITS];
  assign cur_x   = field_x[`RASTER_SCREEN_BITS-1:0];
  assign cur_y   = field_y[`RASTER_SCREEN_BITS-1:0];

  // Pop both FIFOs together, one pair outstanding at a time
  assign rd_en = (state == ASM_COLLECT) && !pending && !vertex_empty && !color_empty;

  assign tri_valid = (state == ASM_HOLD);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= ASM_COLLECT;
      slot    <= 2'd0;
      pending <= 1'b0;
    end
    else
    begin
      pending <= rd_en;
      case (state)
        ASM_COLLECT:
        begin
          if (pending)
          begin
            if (slot == 2'd2)
            begin
              state <= ASM_HOLD;
              slot  <= 2'd0;
            end
            else
            begin
              slot <= slot + 2'd1;
            end
          end
        end
        ASM_HOLD:
        begin
          // Next triangle starts right after the handoff
          if (tri_ready)
          begin
            state <= ASM_COLLECT;
          end
        end
        default: state <= ASM_COLLECT;
      endcase
    end
  end

  // Capture returned words into the vertex slot
  always_ff @(posedge clk)
  begin
    if (pending)
    begin
      case (slot)
        2'd0:
        begin
          x0        <= cur_x;
          y0        <= cur_y;
          // Flat shading, first color wins
          tri_color <= color_rd_data;
        end
        2'd1:
        begin
          x1 <= cur_x;
          y1 <= cur_y;
        end
        default:
        begin
          x2 <= cur_x;
          y2 <= cur_y;
        end
      endcase
    end
  end

endmodule

// ==== design/triangle_rasterizer.sv ====
module triangle_rasterizer (
  input  logic               clk,
  input  logic               rst,
  input  logic               tri_valid,
  output logic               tri_ready,
  input  raster_pkg::coord_t x0,
  input  raster_pkg::coord_t y0,
  input  raster_pkg::coord_t x1,
  input  raster_pkg::coord_t y1,
  input  raster_pkg::coord_t x2,
  input  raster_pkg::coord_t y2,
  input  raster_pkg::word_t  tri_color,
  input  logic               pix_full,
  output logic               pix_wr_en,
  output raster_pkg::coord_t pix_x,
  output raster_pkg::coord_t pix_y,
  output raster_pkg::word_t  pix_color
);

  import raster_pkg::*;

  ras_state_t state;

  // Latched triangle
  coord_t vx0;
  coord_t vy0;
  coord_t vx1;
  coord_t vy1;
  coord_t vx2;
  coord_t vy2;
  word_t  color_q;

  // Box limits and scan position
  coord_t min_x;
  coord_t max_x;
  coord_t max_y;
  coord_t px;
  coord_t py;

  edge_t  area;
  edge_t  e0;
  edge_t  e1;
  edge_t  e2;
  logic   covered;
  logic   last_pixel;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Edge from a to b, tested at point c
  function automatic edge_t edge_fn(input coord_t ax, input coord_t ay,
                                    input coord_t bx, input coord_t by,
                                    input coord_t cx, input coord_t cy);
    edge_t dx_ab;
    edge_t dy_ab;
    edge_t dx_ac;
    edge_t dy_ac;
    dx_ab = edge_t'(bx) - edge_t'(ax);
    dy_ab = edge_t'(by) - edge_t'(ay);
    dx_ac = edge_t'(cx) - edge_t'(ax);
    dy_ac = edge_t'(cy) - edge_t'(ay);
    return dx_ab * dy_ac - dy_ab * dx_ac;
  endfunction

  function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
    coord_t m;
    m = (a < b) ? a : b;
    return (c < m) ? c : m;
  endfunction

  function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
    coord_t m;
    m = (a > b) ? a : b;
    return (c > m) ? c : m;
  endfunction

  //////////////////////////////
  // Coverage
  //////////////////////////////

  // Twice the signed area, zero means a degenerate triangle
  assign area = edge_fn(vx0, vy0, vx1, vy1, vx2, vy2);

  assign e0 = edge_fn(vx0, vy0, vx1, vy1, px, py);
  assign e1 = edge_fn(vx1, vy1, vx2, vy2, px, py);
  assign e2 = edge_fn(vx2, vy2, vx0, vy0, px, py);

  // Either winding is accepted
  assign covered = ((e0 >= 0) && (e1 >= 0) && (e2 >= 0)) ||
                   ((e0 <= 0) && (e1 <= 0) && (e2 <= 0));

  assign last_pixel = (px == max_x) && (py == max_y);

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign tri_ready = (state == RAS_IDLE);
  assign pix_wr_en = (state == RAS_SCAN) && covered && !pix_full;
  assign pix_x     = px;
  assign pix_y     = py;
  assign pix_color = color_q;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= RAS_IDLE;
    end
    else
    begin
      case (state)
        RAS_IDLE:
        begin
          if (tri_valid)
          begin
            state <= RAS_SETUP;
          end
        end
        RAS_SETUP:
        begin
          state <= (area == 0) ? RAS_IDLE : RAS_SCAN;
        end
        RAS_SCAN:
        begin
          if (!pix_full && last_pixel)
          begin
            state <= RAS_IDLE;
          end
        end
        default: state <= RAS_IDLE;
      endcase
    end
  end

  // Triangle latch, box setup and scan stepping
  always_ff @(posedge clk)
  begin
    case (state)
      RAS_IDLE:
      begin
        if (tri_valid)
        begin
          vx0     <= x0;
          vy0     <= y0;
          vx1     <= x1;
          vy1     <= y1;
          vx2     <= x2;
          vy2     <= y2;
          color_q <= tri_color;
        end
      end
      RAS_SETUP:
      begin
        min_x <= min3(vx0, vx1, vx2);
        max_x <= max3(vx0, vx1, vx2);
        max_y <= max3(vy0, vy1, vy2);
        px    <= min3(vx0, vx1, vx2);
        py    <= min3(vy0, vy1, vy2);
      end
      RAS_SCAN:
      begin
        // Position frozen while the framebuffer is full
        if (!pix_full)
        begin
          if (px == max_x)
          begin
            px <= min_x;
            py <= py + 1'b1;
          end
          else
          begin
            px <= px + 1'b1;
          end
        end
      end
      default:
      begin
        px <= px;
      end
    endcase
  end

endmodule

// ==== sim/raster_assert.sv ====
module raster_assert (
  input logic clk,
  input logic rst,
  input logic pix_full,
  input logic pix_wr_en,
  input logic tri_valid,
  input logic tri_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  // Framebuffer port only writes when there is room
  no_write_when_full: assert property (
    @(posedge clk) disable iff (rst) pix_wr_en |-> !pix_full
  ) else $error("pix_wr_en high while pix_full is high");

  // Outputs quiet in the first cycle out of reset
  quiet_after_reset: assert property (
    @(posedge clk) $fell(rst) |-> (!pix_wr_en && !tri_valid)
  ) else $error("pix_wr_en or tri_valid high right after reset");

  // Triangle offer held until the rasterizer takes it
  valid_held: assert property (
    @(posedge clk) disable iff (rst) (tri_valid && !tri_ready) |=> tri_valid
  ) else $error("tri_valid dropped before tri_ready");

endmodule

bind raster_top raster_assert assert_inst (
  .clk       (clk),
  .rst       (rst),
  .pix_full  (pix_full),
  .pix_wr_en (pix_wr_en),
  .tri_valid (tri_valid),
  .tri_ready (tri_ready)
);

// ==== sim/raster_checker.sv ====
module raster_checker (
  input  logic               clk,
  input  logic               rst,
  input  logic               pix_wr_en,
  input  logic               pix_full,
  input  raster_pkg::coord_t pix_x,
  input  raster_pkg::coord_t pix_y,
  input  raster_pkg::word_t  pix_color,
  input  logic               exp_push,
  input  raster_pkg::coord_t exp_x,
  input  raster_pkg::coord_t exp_y,
  input  raster_pkg::word_t  exp_color,
  output int                 pending,
  output int                 mismatch_count,
  output int                 unexpected_count
);

  timeunit 1ns;
  timeprecision 1ps;

  import raster_pkg::*;

  typedef struct packed {
    coord_t x;
    coord_t y;
    word_t  color;
  } expect_t;

  expect_t expect_q[$];

  // New expectations go in before the pixel of the same edge is matched
  always @(posedge clk)
  begin : compare
    expect_t want;
    expect_t item;
    if (rst)
    begin
      expect_q.delete();
      mismatch_count   = 0;
      unexpected_count = 0;
    end
    else
    begin
      if (exp_push)
      begin
        item.x     = exp_x;
        item.y     = exp_y;
        item.color = exp_color;
        expect_q.push_back(item);
      end
      if (pix_wr_en)
      begin
        if (pix_full)
        begin
          $display("FAILED at %0t ns: pixel (%0d,%0d) written while pix_full is high",
                   $time, pix_x, pix_y);
          mismatch_count++;
        end
        if (expect_q.size() == 0)
        begin
          $display("FAILED at %0t ns: unexpected pixel (%0d,%0d) color %h",
                   $time, pix_x, pix_y, pix_color);
          unexpected_count++;
        end
        else
        begin
          want = expect_q.pop_front();
          if ((pix_x !== want.x) || (pix_y !== want.y) || (pix_color !== want.color))
          begin
            $display("FAILED at %0t ns: pixel (%0d,%0d) color %h, expected (%0d,%0d) color %h",
                     $time, pix_x, pix_y, pix_color, want.x, want.y, want.color);
            mismatch_count++;
          end
        end
      end
    end
    pending = expect_q.size();
  end

endmodule

// ==== sim/raster_tb.sv ====
module raster_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import raster_pkg::*;

  localparam int FULL_TIMEOUT  = 10000;
  localparam int DRAIN_TIMEOUT = 300000;
  localparam int IDLE_CYCLES   = 100;

  typedef struct packed {
    coord_t y;
    coord_t x;
  } pix_t;

  typedef pix_t pix_list_t[$];

  logic   clk;
  logic   rst;
  logic   vertex_wr_en;
  word_t  vertex_wr_data;
  logic   vertex_full;
  logic   color_wr_en;
  word_t  color_wr_data;
  logic   color_full;
  logic   pix_full = 1'b0;
  logic   pix_wr_en;
  coord_t pix_x;
  coord_t pix_y;
  word_t  pix_color;
  logic   exp_push;
  coord_t exp_x;
  coord_t exp_y;
  word_t  exp_color;
  int     pending;
  int     mismatch_count;
  int     unexpected_count;
  int     timeout_count;
  int     flag_count;
  logic   stall_mode = 1'b0;

  tb_clock #(.PERIOD(8)) clock_inst (.clk(clk));

  raster_top raster_top_inst (
    .clk            (clk),
    .rst            (rst),
    .vertex_wr_en   (vertex_wr_en),
    .vertex_wr_data (vertex_wr_data),
    .vertex_full    (vertex_full),
    .color_wr_en    (color_wr_en),
    .color_wr_data  (color_wr_data),
    .color_full     (color_full),
    .pix_full       (pix_full),
    .pix_wr_en      (pix_wr_en),
    .pix_x          (pix_x),
    .pix_y          (pix_y),
    .pix_color      (pix_color)
  );

  raster_checker checker_inst (
    .clk              (clk),
    .rst              (rst),
    .pix_wr_en        (pix_wr_en),
    .pix_full         (pix_full),
    .pix_x            (pix_x),
    .pix_y            (pix_y),
    .pix_color        (pix_color),
    .exp_push         (exp_push),
    .exp_x            (exp_x),
    .exp_y            (exp_y),
    .exp_color        (exp_color),
    .pending          (pending),
    .mismatch_count   (mismatch_count),
    .unexpected_count (unexpected_count)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int edge_value(input int ax, input int ay, input int bx, input int by,
                                    input int px, input int py);
    return (bx - ax) * (py - ay) - (by - ay) * (px - ax);
  endfunction

  function automatic int min_of3(input int a, input int b, input int c);
    int m;
    m = (a < b) ? a : b;
    return (c < m) ? c : m;
  endfunction

  function automatic int max_of3(input int a, input int b, input int c);
    int m;
    m = (a > b) ? a : b;
    return (c > m) ? c : m;
  endfunction

  // Covered pixels of the bounding box in scan order
  function automatic pix_list_t ref_pixels(input int ax, input int ay, input int bx,
                                           input int by, input int cx, input int cy);
    pix_list_t list;
    pix_t      pix;
    int        px;
    int        py;
    int        e0;
    int        e1;
    int        e2;
    if (edge_value(ax, ay, bx, by, cx, cy) != 0)
    begin
      for (py = min_of3(ay, by, cy); py <= max_of3(ay, by, cy); py++)
      begin
        for (px = min_of3(ax, bx, cx); px <= max_of3(ax, bx, cx); px++)
        begin
          e0 = edge_value(ax, ay, bx, by, px, py);
          e1 = edge_value(bx, by, cx, cy, px, py);
          e2 = edge_value(cx, cy, ax, ay, px, py);
          if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0))
          begin
            pix.x = coord_t'(px);
            pix.y = coord_t'(py);
            list.push_back(pix);
          end
        end
      end
    end
    return list;
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic word_t make_vertex(input int x, input int y);
    return {field_t'(x), field_t'(y), field_t'($urandom)};
  endfunction

  function automatic word_t random_color();
    return {$urandom, $urandom, $urandom};
  endfunction

  task automatic push_expected(input pix_list_t list, input word_t color);
    foreach (list[i])
    begin
      exp_push  = 1'b1;
      exp_x     = list[i].x;
      exp_y     = list[i].y;
      exp_color = color;
      @(negedge clk);
    end
    exp_push = 1'b0;
  endtask

  task automatic write_pair(input word_t vword, input word_t cword);
    int waited;
    waited = 0;
    while ((vertex_full || color_full) && waited < FULL_TIMEOUT)
    begin
      vertex_wr_en = 1'b0;
      color_wr_en  = 1'b0;
      @(negedge clk);
      waited++;
    end
    if (vertex_full || color_full)
    begin
      $display("Timeout: input FIFO still full after %0d cycles", waited);
      timeout_count++;
    end
    vertex_wr_en   = 1'b1;
    vertex_wr_data = vword;
    color_wr_en    = 1'b1;
    color_wr_data  = cword;
    @(negedge clk);
    vertex_wr_en = 1'b0;
    color_wr_en  = 1'b0;
  endtask

  // Expectations are queued before the words can reach the DUT
  task automatic send_triangle(input int ax, input int ay, input int bx, input int by,
                               input int cx, input int cy, input word_t color);
    pix_list_t expected;
    expected = ref_pixels(ax, ay, bx, by, cx, cy);
    push_expected(expected, color);
    write_pair(make_vertex(ax, ay), color);
    write_pair(make_vertex(bx, by), random_color());
    write_pair(make_vertex(cx, cy), random_color());
  endtask

  // Input FIFOs are empty here, so neither may report full
  task automatic check_not_full(input string label);
    if ((vertex_full !== 1'b0) || (color_full !== 1'b0))
    begin
      $display("FAILED at %0t ns: %s, vertex_full %b color_full %b with empty FIFOs",
               $time, label, vertex_full, color_full);
      flag_count++;
    end
  endtask

  task automatic wait_for_drain(input string label);
    int waited;
    waited = 0;
    while (pending != 0 && waited < DRAIN_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (pending != 0)
    begin
      $display("Timeout: %0d expected pixels never arrived in %s", pending, label);
      timeout_count++;
    end
    // Window for stray pixels after the last expected one
    repeat (IDLE_CYCLES) @(negedge clk);
    check_not_full(label);
  endtask

  // Random back pressure from the framebuffer side
  always @(negedge clk)
  begin
    pix_full = stall_mode && ($urandom_range(3) == 0);
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    int n;
    void'($urandom(8));
    rst            = 1'b1;
    vertex_wr_en   = 1'b0;
    vertex_wr_data = '0;
    color_wr_en    = 1'b0;
    color_wr_data  = '0;
    exp_push       = 1'b0;
    exp_x          = '0;
    exp_y          = '0;
    exp_color      = '0;
    timeout_count  = 0;
    flag_count     = 0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    // Nothing supplied yet so any pixel here is unexpected
    repeat (IDLE_CYCLES) @(negedge clk);
    check_not_full("after reset");

    send_triangle(1, 1, 1, 10, 10, 1, 96'h0000_00ff_0000_0080_0000_0010);
    wait_for_drain("single triangle");

    // Opposite winding gives the same scan result
    send_triangle(10, 1, 1, 10, 1, 1, 96'h0000_00ff_0000_0080_0000_0010);
    wait_for_drain("reversed triangle");

    // Collinear points then a normal triangle
    send_triangle(2, 2, 5, 5, 9, 9, random_color());
    send_triangle(20, 20, 30, 22, 24, 35, random_color());
    wait_for_drain("degenerate triangle");

    stall_mode = 1'b1;
    send_triangle(0, 0, 40, 5, 12, 30, random_color());
    send_triangle(63, 63, 50, 40, 60, 33, random_color());
    wait_for_drain("back pressure");
    stall_mode = 1'b0;

    for (n = 0; n < 20; n++)
    begin
      send_triangle($urandom_range(63), $urandom_range(63), $urandom_range(63),
                    $urandom_range(63), $urandom_range(63), $urandom_range(63),
                    random_color());
    end
    wait_for_drain("random triangles");

    $display("Summary: mismatches %0d, unexpected pixels %0d, full flag errors %0d, timeouts %0d",
             mismatch_count, unexpected_count, flag_count, timeout_count);
    if (mismatch_count == 0 && unexpected_count == 0 && flag_count == 0 &&
        timeout_count == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/tb_clock.sv ====
module tb_clock #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk = 1'b0;
  end

  // Free running, even duty cycle
  always
  begin
    #(PERIOD / 2);
    clk = ~clk;
  end

endmodule

// ==== src.f ====
+incdir+design
design/raster_pkg.sv
design/sync_fifo.sv
design/triangle_assembler.sv
design/triangle_rasterizer.sv
design/raster_top.sv
sim/tb_clock.sv
sim/raster_checker.sv
sim/raster_assert.sv
sim/raster_tb.sv
